/* burst_ctrl.sv */
`timescale 1ns/1ps

module burst_ctrl #(
    parameter int NUM_Q = 8,
    parameter int CNT_W = 5
) (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_found,
    input  logic [sched_cfg_pkg::IDX_WIDTH-1:0] i_idx,
    input  logic [CNT_W-1:0]                    i_weight,
    output logic                                o_grant,
    output logic [NUM_Q-1:0]                    o_pq_rd_en,
    output logic [sched_cfg_pkg::IDX_WIDTH-1:0] o_pq_sel,
    output logic                                o_cache_en
);

    localparam int IW = sched_cfg_pkg::IDX_WIDTH;

    sched_ctrl_pkg::burst_state_e state_q;
    sched_ctrl_pkg::burst_state_e state_d;

    logic [IW-1:0]    sel_q;
    logic [CNT_W-1:0] remain_q;
    logic             last_read;
    logic             rd_active;
    logic             cache_en_q;

    //////////////////////////////
    // grant decision
    //////////////////////////////

    // accept a choice only between bursts
    assign o_grant = (state_q == sched_ctrl_pkg::ST_IDLE) && i_found;

    // guard against a zero weight as well as the normal last beat
    assign last_read = (remain_q <= CNT_W'(1));

    assign rd_active = (state_q == sched_ctrl_pkg::ST_READ);

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            sched_ctrl_pkg::ST_IDLE: begin
                if (i_found) begin
                    state_d = sched_ctrl_pkg::ST_READ;
                end
            end
            sched_ctrl_pkg::ST_READ: begin
                if (last_read) begin
                    state_d = sched_ctrl_pkg::ST_TAIL;
                end
            end
            sched_ctrl_pkg::ST_TAIL: begin
                // queue count catches up with the last pop here
                state_d = sched_ctrl_pkg::ST_IDLE;
            end
            default: begin
                state_d = sched_ctrl_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= sched_ctrl_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // selection and burst count
    //////////////////////////////

    // index and weight captured together at grant
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sel_q    <= '0;
            remain_q <= '0;
        end else if (o_grant) begin
            sel_q    <= i_idx;
            remain_q <= i_weight;
        end else if (rd_active && !last_read) begin
            remain_q <= remain_q - 1'b1;
        end
    end

    assign o_pq_sel = sel_q;

    //////////////////////////////
    // read and cache enables
    //////////////////////////////

    // one-hot decode of the held index
    always_comb begin
        o_pq_rd_en = '0;
        if (rd_active) begin
            o_pq_rd_en = NUM_Q'(1) << sel_q;
        end
    end

    // queue data shows up one cycle after the read
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cache_en_q <= 1'b0;
        end else begin
            cache_en_q <= |o_pq_rd_en;
        end
    end

    assign o_cache_en = cache_en_q;

    //////////////////////////////
    // checks
    //////////////////////////////

    a_rd_onehot: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(o_pq_rd_en)
    ) else $error("burst_ctrl: read enable not one-hot 0x%0h", o_pq_rd_en);

    // selection must hold for the whole burst
    a_sel_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        rd_active ##1 rd_active |-> $stable(o_pq_sel)
    ) else $error("burst_ctrl: queue select changed inside a burst");

endmodule

/* queue_pick.sv */
`timescale 1ns/1ps

module queue_pick #(
    parameter int NUM_Q = 8,
    parameter int CNT_W = 5
) (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  sched_ctrl_pkg::sched_mode_e        i_wrr_mode,
    input  logic [NUM_Q-1:0]                   i_pq_empty,
    input  logic [NUM_Q*CNT_W-1:0]             i_queue_cnt,
    input  logic                               i_grant,
    output logic                               o_found,
    output logic [sched_cfg_pkg::IDX_WIDTH-1:0] o_idx,
    output logic [CNT_W-1:0]                   o_weight
);

    localparam int IW = sched_cfg_pkg::IDX_WIDTH;

    logic [IW-1:0]    rr_ptr;
    logic [IW-1:0]    search_start;
    logic [CNT_W-1:0] cnt_arr [NUM_Q];
    logic [CNT_W-1:0] sel_cnt;

    //////////////////////////////
    // count unpacking
    //////////////////////////////

    always_comb begin
        for (int q = 0; q < NUM_Q; q++) begin
            cnt_arr[q] = i_queue_cnt[q*CNT_W +: CNT_W];
        end
    end

    //////////////////////////////
    // rotating search
    //////////////////////////////

    // strict priority always looks from queue 0
    assign search_start = (i_wrr_mode == sched_ctrl_pkg::MODE_WRR) ? rr_ptr : '0;

    always_comb begin
        int cand;
        o_found = 1'b0;
        o_idx   = '0;
        for (int k = 0; k < NUM_Q; k++) begin
            cand = int'(search_start) + k;
            // wrap the candidate back around to queue 0
            if (cand >= NUM_Q) begin
                cand = cand - NUM_Q;
            end
            if (!o_found && !i_pq_empty[cand]) begin
                o_found = 1'b1;
                o_idx   = IW'(cand);
            end
        end
    end

    //////////////////////////////
    // weight lookup
    //////////////////////////////

    assign sel_cnt = cnt_arr[o_idx];

    // single read per grant in strict mode
    assign o_weight = (i_wrr_mode == sched_ctrl_pkg::MODE_WRR) ? sel_cnt : CNT_W'(1);

    //////////////////////////////
    // round-robin pointer
    //////////////////////////////

    // next search starts just after the queue that was granted
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rr_ptr <= '0;
        end else if (i_grant) begin
            if (int'(o_idx) == NUM_Q - 1) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= o_idx + 1'b1;
            end
        end
    end

    // a non-empty queue must report a count, or the burst would be empty
    a_found_weight: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_found |-> (o_weight != '0)
    ) else $error("queue_pick: non-empty queue %0d with zero weight", o_idx);

endmodule

/* queue_sched_top.sv */
`timescale 1ns/1ps

module queue_sched_top #(
    parameter int NUM_Q = sched_cfg_pkg::NUM_QUEUES,
    parameter int CNT_W = sched_cfg_pkg::CNT_WIDTH
) (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  sched_ctrl_pkg::sched_mode_e         i_wrr_mode,
    input  logic [NUM_Q-1:0]                    i_pq_empty,
    input  logic [NUM_Q*CNT_W-1:0]              i_queue_cnt,
    output logic [NUM_Q-1:0]                    o_pq_rd_en,
    output logic [sched_cfg_pkg::IDX_WIDTH-1:0] o_pq_sel,
    output logic                                o_cache_en
);

    //////////////////////////////
    // picker to controller
    //////////////////////////////

    logic                                found;
    logic [sched_cfg_pkg::IDX_WIDTH-1:0] pick_idx;
    logic [CNT_W-1:0]                    pick_weight;
    logic                                grant;

    // queue choice and burst length
    queue_pick #(
        .NUM_Q (NUM_Q),
        .CNT_W (CNT_W)
    ) i_queue_pick (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wrr_mode  (i_wrr_mode),
        .i_pq_empty  (i_pq_empty),
        .i_queue_cnt (i_queue_cnt),
        .i_grant     (grant),
        .o_found     (found),
        .o_idx       (pick_idx),
        .o_weight    (pick_weight)
    );

    // burst sequencing toward the queues and the cache
    burst_ctrl #(
        .NUM_Q (NUM_Q),
        .CNT_W (CNT_W)
    ) i_burst_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_found    (found),
        .i_idx      (pick_idx),
        .i_weight   (pick_weight),
        .o_grant    (grant),
        .o_pq_rd_en (o_pq_rd_en),
        .o_pq_sel   (o_pq_sel),
        .o_cache_en (o_cache_en)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the scheduler testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_queue_sched \
    --Mdir "$build_dir"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/Vtb_queue_sched" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "=== FAIL ===" "$log_file"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

/* sched_cfg_pkg.sv */
package sched_cfg_pkg;

    //////////////////////////////
    // queue sizing
    //////////////////////////////

    // number of priority queues served by the scheduler
    // queue 0 has the highest priority in strict mode
    localparam int NUM_QUEUES = 8;

    // width of one fill count reported by a queue
    // also the width of the burst counter
    localparam int CNT_WIDTH = 5;

    //////////////////////////////
    // derived widths
    //////////////////////////////

    // index of one queue with at least one bit
    localparam int IDX_WIDTH = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;

endpackage

/* sched_ctrl_pkg.sv */
package sched_ctrl_pkg;

    //////////////////////////////
    // scheduling strategy
    //////////////////////////////

    // strict priority reads one item from the lowest-index non-empty queue
    // weighted round robin reads a burst of count items and rotates its search
    typedef enum logic [0:0] {
        MODE_SP  = 1'b0,
        MODE_WRR = 1'b1
    } sched_mode_e;

    //////////////////////////////
    // burst controller states
    //////////////////////////////

    // tail gives the queue one cycle to settle its count
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_READ = 2'd1,
        ST_TAIL = 2'd2
    } burst_state_e;

endpackage

/* tb_queue_model.sv */
`timescale 1ns/1ps

module tb_queue_model #(
    parameter int NUM_Q     = 8,
    parameter int CNT_W     = 5,
    parameter int MAX_FILL  = 9,
    parameter int PUSH_ODDS = 32
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_push_en,
    input  logic [NUM_Q-1:0]       i_rd_en,
    output logic [NUM_Q-1:0]       o_pq_empty,
    output logic [NUM_Q*CNT_W-1:0] o_queue_cnt
);

    int               fill [NUM_Q];
    logic [NUM_Q-1:0] pop_seen;
    logic             push_seen;
    logic             rst_seen;

    //////////////////////////////
    // queue flags toward the DUT
    //////////////////////////////

    // empty flag and packed count with queue 0 in the low bits
    task automatic drive_outputs();
        for (int q = 0; q < NUM_Q; q++) begin
            o_pq_empty[q]                 = (fill[q] == 0);
            o_queue_cnt[q*CNT_W +: CNT_W] = CNT_W'(fill[q]);
        end
    endtask

    initial begin
        pop_seen  = '0;
        push_seen = 1'b0;
        rst_seen  = 1'b0;
        for (int q = 0; q < NUM_Q; q++) begin
            fill[q] = 0;
        end
        drive_outputs();
    end

    // controls are settled mid-cycle
    always @(negedge i_clk) begin
        pop_seen  = i_rd_en;
        push_seen = i_push_en;
        rst_seen  = i_rst_n;
    end

    //////////////////////////////
    // pop and push per cycle
    //////////////////////////////

    // one read takes one item and pushes arrive at random
    always @(posedge i_clk) begin
        #1;
        for (int q = 0; q < NUM_Q; q++) begin
            if (!rst_seen) begin
                fill[q] = 0;
            end else begin
                if (pop_seen[q] && fill[q] > 0) begin
                    fill[q] = fill[q] - 1;
                end
                if (push_seen && fill[q] < MAX_FILL) begin
                    if (($urandom % PUSH_ODDS) == 0) begin
                        fill[q] = fill[q] + 1;
                    end
                end
            end
        end
        drive_outputs();
    end

endmodule

/* tb_queue_sched.sv */
`timescale 1ns/1ps

module tb_queue_sched;

    localparam int NUM_Q = sched_cfg_pkg::NUM_QUEUES;
    localparam int CNT_W = sched_cfg_pkg::CNT_WIDTH;
    localparam int IW    = sched_cfg_pkg::IDX_WIDTH;

    logic                        clk;
    logic                        rst_n;
    sched_ctrl_pkg::sched_mode_e wrr_mode;
    logic                        push_en;
    logic [NUM_Q-1:0]            pq_empty;
    logic [NUM_Q*CNT_W-1:0]      queue_cnt;
    logic [NUM_Q-1:0]            pq_rd_en;
    logic [IW-1:0]               pq_sel;
    logic                        cache_en;

    int mismatch_cnt;
    int fail_cnt;
    int sp_bursts;
    int wrr_bursts;
    int long_bursts;

    // reference state refreshed on the falling edge
    int               rr_exp;
    int               pick_exp;
    int               len_exp;
    int               burst_q;
    int               burst_len;
    int               beat;
    int               end_beats;
    int               end_len;
    int               empty_run;
    logic             burst_end;
    logic             rd_any_d;
    logic             cache_exp;
    logic [NUM_Q-1:0] rd_seen;
    logic [IW-1:0]    sel_seen;
    logic             cache_seen;

    queue_sched_top #(
        .NUM_Q (NUM_Q),
        .CNT_W (CNT_W)
    ) i_queue_sched_top (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_wrr_mode  (wrr_mode),
        .i_pq_empty  (pq_empty),
        .i_queue_cnt (queue_cnt),
        .o_pq_rd_en  (pq_rd_en),
        .o_pq_sel    (pq_sel),
        .o_cache_en  (cache_en)
    );

    tb_queue_model #(
        .NUM_Q     (NUM_Q),
        .CNT_W     (CNT_W),
        .MAX_FILL  (9),
        .PUSH_ODDS (32)
    ) i_queue_model (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_push_en   (push_en),
        .i_rd_en     (pq_rd_en),
        .o_pq_empty  (pq_empty),
        .o_queue_cnt (queue_cnt)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    //////////////////////////////
    // reference scheduler
    //////////////////////////////

    // first non-empty queue when searching cyclically from start
    function automatic int first_ready(input logic [NUM_Q-1:0] empty, input int start);
        int q;
        int found;
        found = start;
        for (int k = NUM_Q - 1; k >= 0; k--) begin
            q = (start + k) % NUM_Q;
            if (!empty[q]) begin
                found = q;
            end
        end
        return found;
    endfunction

    always @(negedge clk) begin
        logic rd_any;
        rd_any     = |pq_rd_en;
        rd_seen    = pq_rd_en;
        sel_seen   = pq_sel;
        cache_seen = cache_en;
        if (!rst_n) begin
            rr_exp    = 0;
            pick_exp  = 0;
            len_exp   = 0;
            beat      = 0;
            empty_run = 0;
            burst_end = 1'b0;
            rd_any_d  = 1'b0;
            cache_exp = 1'b0;
        end else begin
            cache_exp = rd_any_d;
            burst_end = !rd_any && rd_any_d;
            if (burst_end) begin
                end_beats = beat;
                end_len   = burst_len;
            end
            if (rd_any && !rd_any_d) begin
                // burst granted from last cycle's choice
                burst_q   = pick_exp;
                burst_len = len_exp;
                beat      = 1;
                rr_exp    = (pick_exp + 1) % NUM_Q;
                if (wrr_mode == sched_ctrl_pkg::MODE_WRR) begin
                    wrr_bursts++;
                    if (len_exp > 1) begin
                        long_bursts++;
                    end
                end else begin
                    sp_bursts++;
                end
            end else if (rd_any) begin
                beat++;
            end
            rd_any_d  = rd_any;
            empty_run = (&pq_empty) ? empty_run + 1 : 0;
            pick_exp  = first_ready(pq_empty,
                                    (wrr_mode == sched_ctrl_pkg::MODE_WRR) ? rr_exp : 0);
            len_exp   = (wrr_mode == sched_ctrl_pkg::MODE_WRR) ?
                        int'(queue_cnt[pick_exp*CNT_W +: CNT_W]) : 1;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic report_mismatch(input string name, input int exp_val, input int got_val);
        mismatch_cnt++;
        $display("mismatch %s exp 0x%0h got 0x%0h at %0t", name, exp_val, got_val, $time);
    endtask

    a_reset_rd: assert property (@(posedge clk)
        (!rst_n || !$past(rst_n)) |-> (pq_rd_en == '0))
        else report_mismatch("o_pq_rd_en", 0, int'(rd_seen));

    a_reset_cache: assert property (@(posedge clk)
        (!rst_n || !$past(rst_n)) |-> !cache_en)
        else report_mismatch("o_cache_en", 0, int'(cache_seen));

    // two empty cycles before this one leave nothing to read
    a_empty_rd: assert property (@(posedge clk) disable iff (!rst_n)
        (empty_run >= 3) |-> (pq_rd_en == '0))
        else report_mismatch("o_pq_rd_en", 0, int'(rd_seen));

    a_empty_cache: assert property (@(posedge clk) disable iff (!rst_n)
        (empty_run >= 3) |-> !cache_en)
        else report_mismatch("o_cache_en", 0, int'(cache_seen));

    a_target: assert property (@(posedge clk) disable iff (!rst_n)
        (pq_rd_en != '0) |-> (pq_rd_en == (NUM_Q'(1) << burst_q)))
        else report_mismatch("o_pq_rd_en", int'(NUM_Q'(1) << burst_q), int'(rd_seen));

    a_sel: assert property (@(posedge clk) disable iff (!rst_n)
        (pq_rd_en != '0) |-> (pq_rd_en == (NUM_Q'(1) << pq_sel)))
        else report_mismatch("o_pq_sel", burst_q, int'(sel_seen));

    a_len_run: assert property (@(posedge clk) disable iff (!rst_n)
        (pq_rd_en != '0) |-> (beat <= burst_len))
        else report_mismatch("burst length", burst_len, beat);

    a_len_end: assert property (@(posedge clk) disable iff (!rst_n)
        burst_end |-> (end_beats == end_len))
        else report_mismatch("burst length", end_len, end_beats);

    a_cache: assert property (@(posedge clk) disable iff (!rst_n)
        cache_en == cache_exp)
        else report_mismatch("o_cache_en", int'(cache_exp), int'(cache_seen));

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic hold_reset(input int cycles);
        rst_n = 1'b0;
        repeat (cycles) step();
        rst_n = 1'b1;
    endtask

    task automatic wait_bursts(input logic wrr, input int target, input int max_cycles);
        int cycles;
        cycles = 0;
        while (((wrr ? wrr_bursts : sp_bursts) < target) && cycles < max_cycles) begin
            step();
            cycles++;
        end
        if ((wrr ? wrr_bursts : sp_bursts) < target) begin
            fail_cnt++;
            $display("timeout: only %0d of %0d bursts seen", wrr ? wrr_bursts : sp_bursts,
                     target);
        end
    endtask

    task automatic wait_drain(input int max_cycles);
        int cycles;
        cycles = 0;
        while (!(empty_run >= 3 && rd_seen == '0) && cycles < max_cycles) begin
            step();
            cycles++;
        end
        if (!(empty_run >= 3 && rd_seen == '0)) begin
            fail_cnt++;
            $display("timeout: queues did not drain within %0d cycles", max_cycles);
        end
    endtask

    initial begin
        void'($urandom(32538));
        wrr_mode = sched_ctrl_pkg::MODE_SP;
        push_en  = 1'b0;
        hold_reset(2);

        // all queues stay empty
        repeat (24) step();

        // strict priority traffic
        push_en = 1'b1;
        wait_bursts(1'b0, 60, 4000);

        // weighted round robin with the pointer back at queue 0
        step();
        push_en  = 1'b0;
        wrr_mode = sched_ctrl_pkg::MODE_WRR;
        hold_reset(2);
        push_en = 1'b1;
        wait_bursts(1'b1, 60, 4000);

        step();
        push_en = 1'b0;
        wait_drain(600);
        repeat (4) step();
        if (long_bursts == 0) begin
            fail_cnt++;
            $display("no weighted burst longer than one read was seen");
        end

        $display("summary: mismatches=%0d failures=%0d sp_bursts=%0d wrr_bursts=%0d",
                 mismatch_cnt, fail_cnt, sp_bursts, wrr_bursts);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verilog.f */
sched_cfg_pkg.sv
sched_ctrl_pkg.sv
queue_pick.sv
burst_ctrl.sv
queue_sched_top.sv
tb_queue_model.sv
tb_queue_sched.sv
